// File: source/vertex_job_pkg.sv
package vertex_job_pkg;

	////////////////////
	// widths
	////////////////////

	typedef logic [31:0] vertex_value_t;
	typedef logic [31:0] vertex_id_t;
	typedef logic [63:0] byte_addr_t;
	typedef logic [11:0] req_size_t;
	typedef logic [3:0]  line_count_t; // valid vertices in one line, up to 8

	localparam int LINE_VERTICES = 8;
	localparam int VERTEX_BYTES  = 4;
	localparam int LINE_BYTES    = 32; // address step between lines
	localparam int NUM_FIELDS    = 6;

	// entry 0 holds the vertex at the lowest address
	typedef vertex_value_t [LINE_VERTICES-1:0] vertex_line_t;

	////////////////////
	// encodings
	////////////////////

	// read tag, also the index of the base in wed_t
	typedef enum logic [2:0] {
		IN_DEGREE      = 3'd0,
		OUT_DEGREE     = 3'd1,
		EDGES_IDX      = 3'd2,
		INV_IN_DEGREE  = 3'd3,
		INV_OUT_DEGREE = 3'd4,
		INV_EDGES_IDX  = 3'd5
	} vertex_field_e;

	typedef enum logic [3:0] {
		SEQ_RESET,
		SEQ_INIT,
		SEQ_WAIT,
		SEQ_CALC,
		SEQ_IDLE,
		SEQ_IN_DEGREE, // one issue state per field from here on
		SEQ_OUT_DEGREE,
		SEQ_EDGES_IDX,
		SEQ_INV_IN_DEGREE,
		SEQ_INV_OUT_DEGREE,
		SEQ_INV_EDGES_IDX
	} seq_state_e;

	////////////////////
	// structs
	////////////////////

	typedef struct packed {
		logic                         valid;
		vertex_id_t                   num_vertices;
		byte_addr_t [NUM_FIELDS-1:0]  base; // indexed by vertex_field_e
	} wed_t;

	typedef struct packed {
		logic          valid;
		byte_addr_t    address;
		req_size_t     size;
		vertex_field_e field;
		line_count_t   count;
	} read_cmd_t;

	typedef struct packed {
		logic          valid;
		vertex_field_e field;
		line_count_t   count;
		vertex_line_t  line;
	} read_data_t;

	typedef struct packed {
		logic          valid;
		vertex_id_t    id;
		vertex_value_t in_degree;
		vertex_value_t out_degree;
		vertex_value_t edges_idx;
		vertex_value_t inv_in_degree;
		vertex_value_t inv_out_degree;
		vertex_value_t inv_edges_idx;
	} vertex_job_t;

endpackage

// File: source/read_command_sequencer.sv
`timescale 1ns/1ps

module read_command_sequencer (
	input  logic                                 clock,
	input  logic                                 rstn,
	input  vertex_job_pkg::wed_t                 wed,
	input  logic                                 read_buffer_alfull,
	input  logic                                 reads_idle,
	input  logic                                 job_alfull,
	input  logic [vertex_job_pkg::NUM_FIELDS-1:0] stream_busy,
	output vertex_job_pkg::read_cmd_t            read_cmd
);
	import vertex_job_pkg::*;

	seq_state_e    state, next_state;
	wed_t          wed_q;
	vertex_id_t    remaining;   // vertices not yet requested
	byte_addr_t    line_offset;
	line_count_t   line_count;  // vertices in the current batch
	line_count_t   calc_count;
	req_size_t     req_size;
	logic          batch_ready;
	logic          issue_next;
	vertex_field_e issue_field;

	// bytes rounded up to a power of two, starting at one vertex
	function automatic req_size_t size_for(line_count_t count);
		req_size_t bytes;
		req_size_t size;
		bytes = req_size_t'(count) * req_size_t'(VERTEX_BYTES);
		size = req_size_t'(VERTEX_BYTES);
		for (int i = 0; i < 4; i++) begin
			if (size < bytes)
				size = size << 1;
		end
		return size;
	endfunction

	assign calc_count = (remaining >= vertex_id_t'(LINE_VERTICES)) ?
		line_count_t'(LINE_VERTICES) : line_count_t'(remaining);

	assign batch_ready = !read_buffer_alfull && !(|stream_busy) && !job_alfull &&
		(remaining != '0) && reads_idle;

	////////////////////
	// batch fsm
	////////////////////

	always_comb begin
		next_state = state;
		case (state)
			SEQ_RESET:          if (wed.valid) next_state = SEQ_INIT;
			SEQ_INIT:           next_state = SEQ_WAIT;
			SEQ_WAIT:           if (batch_ready) next_state = SEQ_CALC;
			SEQ_CALC:           next_state = SEQ_IDLE;
			SEQ_IDLE:           if (!read_buffer_alfull) next_state = SEQ_IN_DEGREE;
			SEQ_IN_DEGREE:      if (!read_buffer_alfull) next_state = SEQ_OUT_DEGREE;
			SEQ_OUT_DEGREE:     if (!read_buffer_alfull) next_state = SEQ_EDGES_IDX;
			SEQ_EDGES_IDX:      if (!read_buffer_alfull) next_state = SEQ_INV_IN_DEGREE;
			SEQ_INV_IN_DEGREE:  if (!read_buffer_alfull) next_state = SEQ_INV_OUT_DEGREE;
			SEQ_INV_OUT_DEGREE: if (!read_buffer_alfull) next_state = SEQ_INV_EDGES_IDX;
			SEQ_INV_EDGES_IDX:  if (!read_buffer_alfull) next_state = SEQ_WAIT;
			default:            next_state = SEQ_RESET;
		endcase
	end

	// command goes out in the first cycle of each issue state
	always_comb begin
		issue_next = 1'b1;
		issue_field = IN_DEGREE;
		case (next_state)
			SEQ_IN_DEGREE:      issue_field = IN_DEGREE;
			SEQ_OUT_DEGREE:     issue_field = OUT_DEGREE;
			SEQ_EDGES_IDX:      issue_field = EDGES_IDX;
			SEQ_INV_IN_DEGREE:  issue_field = INV_IN_DEGREE;
			SEQ_INV_OUT_DEGREE: issue_field = INV_OUT_DEGREE;
			SEQ_INV_EDGES_IDX:  issue_field = INV_EDGES_IDX;
			default:            issue_next = 1'b0;
		endcase
		if (next_state == state)
			issue_next = 1'b0; // stalled, already sent
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state <= SEQ_RESET;
			remaining <= '0;
			line_offset <= '0;
		end else begin
			state <= next_state;
			if (state == SEQ_INIT) begin
				remaining <= wed.num_vertices;
				line_offset <= '0;
			end
			if (state == SEQ_CALC)
				remaining <= remaining - vertex_id_t'(calc_count);
			if (state == SEQ_INV_EDGES_IDX && next_state == SEQ_WAIT)
				line_offset <= line_offset + byte_addr_t'(LINE_BYTES); // next line
		end
	end

	always_ff @(posedge clock) begin
		if (state == SEQ_INIT)
			wed_q <= wed;
		if (state == SEQ_CALC) begin
			line_count <= calc_count;
			req_size <= size_for(calc_count);
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_cmd <= '0;
		end else begin
			read_cmd.valid <= issue_next;
			read_cmd.address <= wed_q.base[issue_field] + line_offset;
			read_cmd.size <= req_size;
			read_cmd.field <= issue_field;
			read_cmd.count <= line_count;
		end
	end

endmodule

// File: source/read_data_router.sv
`timescale 1ns/1ps

module read_data_router (
	input  logic                                  clock,
	input  logic                                  rstn,
	input  logic                                  read_cmd_valid,
	input  vertex_job_pkg::read_data_t            read_data,
	output logic [vertex_job_pkg::NUM_FIELDS-1:0] load,
	output vertex_job_pkg::vertex_line_t          load_line,
	output vertex_job_pkg::line_count_t           load_count,
	input  logic [vertex_job_pkg::NUM_FIELDS-1:0] stream_busy,
	output logic                                  reads_idle,
	output logic                                  drain
);
	import vertex_job_pkg::*;

	read_data_t beat_q;
	logic [3:0] outstanding; // at most six per batch

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			beat_q <= '0;
		else
			beat_q <= read_data;
	end

	// one-hot load from the tag
	always_comb begin
		for (int f = 0; f < NUM_FIELDS; f++)
			load[f] = beat_q.valid && (beat_q.field == vertex_field_e'(f));
	end

	assign load_line = beat_q.line;
	assign load_count = beat_q.count;

	// a beat retires when it is loaded into its stream
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			outstanding <= '0;
		else
			outstanding <= outstanding + 4'(read_cmd_valid) - 4'(beat_q.valid);
	end

	assign reads_idle = (outstanding == '0);
	assign drain = reads_idle && (|stream_busy); // whole batch is in

endmodule

// File: source/vertex_field_stream.sv
`timescale 1ns/1ps

module vertex_field_stream (
	input  logic                          clock,
	input  logic                          rstn,
	input  logic                          load,
	input  logic                          drain,
	input  vertex_job_pkg::vertex_line_t  load_line,
	input  vertex_job_pkg::line_count_t   load_count,
	output vertex_job_pkg::vertex_value_t field_value,
	output logic                          field_valid,
	output logic                          busy
);
	import vertex_job_pkg::*;

	vertex_line_t line_q;
	line_count_t  left; // entries still to shift out

	assign busy = (left != '0);
	assign field_valid = drain && busy;
	assign field_value = line_q[0];

	////////////////////
	// entry count
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			left <= '0;
		end else begin
			if (load)
				left <= load_count;
			else if (field_valid)
				left <= left - 1'b1;
		end
	end

	////////////////////
	// line shifter
	////////////////////

	always_ff @(posedge clock) begin
		if (load)
			line_q <= load_line;
		else if (field_valid)
			line_q <= {vertex_value_t'(0), line_q[LINE_VERTICES-1:1]}; // next vertex to 0
	end

endmodule

// File: source/vertex_assembler.sv
`timescale 1ns/1ps

module vertex_assembler (
	input  logic                                           clock,
	input  logic                                           rstn,
	input  vertex_job_pkg::vertex_value_t [vertex_job_pkg::NUM_FIELDS-1:0] field_value,
	input  logic [vertex_job_pkg::NUM_FIELDS-1:0]          field_valid,
	output vertex_job_pkg::vertex_job_t                    job_in,
	output logic                                           job_push,
	output vertex_job_pkg::vertex_id_t                     pushed_count,
	output vertex_job_pkg::vertex_id_t                     filtered_count
);
	import vertex_job_pkg::*;

	vertex_job_t record;
	vertex_id_t  next_id;
	logic        all_valid;
	logic        filter;

	assign all_valid = &field_valid;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			record <= '0;
			next_id <= '0;
		end else begin
			record.valid <= all_valid;
			if (all_valid) begin
				next_id <= next_id + 1'b1; // filtered vertices take an id too
				record.id <= next_id;
				record.in_degree <= field_value[IN_DEGREE];
				record.out_degree <= field_value[OUT_DEGREE];
				record.edges_idx <= field_value[EDGES_IDX];
				record.inv_in_degree <= field_value[INV_IN_DEGREE];
				record.inv_out_degree <= field_value[INV_OUT_DEGREE];
				record.inv_edges_idx <= field_value[INV_EDGES_IDX];
			end
		end
	end

	// no outgoing neighbours, nothing to schedule
	assign filter = record.valid && (record.inv_out_degree == '0);
	assign job_push = record.valid && !filter;
	assign job_in = record;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			pushed_count <= '0;
			filtered_count <= '0;
		end else begin
			if (job_push)
				pushed_count <= pushed_count + 1'b1;
			if (filter)
				filtered_count <= filtered_count + 1'b1;
		end
	end

endmodule

// File: source/vertex_job_queue.sv
`timescale 1ns/1ps

module vertex_job_queue #(
	parameter int JOB_DEPTH = 16
) (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        push,
	input  vertex_job_pkg::vertex_job_t push_data,
	input  logic                        pop,
	output vertex_job_pkg::vertex_job_t head,
	output logic                        valid,
	output logic                        alfull
);
	import vertex_job_pkg::*;

	localparam int ALFULL_MARGIN = LINE_VERTICES;
	localparam int PW = $clog2(JOB_DEPTH);
	localparam int CW = $clog2(JOB_DEPTH + 1);

	vertex_job_t    mem [JOB_DEPTH];
	logic [PW-1:0]  wr_ptr, rd_ptr;
	logic [CW-1:0]  count, free_slots;
	logic           full, do_push, do_pop;

	assign full = (count == CW'(JOB_DEPTH));
	assign do_push = push && !full;
	assign do_pop = pop && valid; // pop on empty is dropped
	assign valid = (count != '0);
	assign head = mem[rd_ptr];   // fall-through head
	assign free_slots = CW'(JOB_DEPTH) - count;
	// a push in flight counts already, so the next batch always fits
	assign alfull = (free_slots - CW'(do_push)) < CW'(ALFULL_MARGIN);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == PW'(JOB_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PW'(JOB_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count + CW'(do_push) - CW'(do_pop);
		end
	end

	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

endmodule

// File: source/vertex_job_control.sv
`timescale 1ns/1ps

module vertex_job_control #(
	parameter int JOB_DEPTH = 16 // at least two lines of vertices
) (
	input  logic                        clock,
	input  logic                        rstn,
	input  vertex_job_pkg::wed_t        wed,
	input  logic                        read_buffer_alfull,
	output vertex_job_pkg::read_cmd_t   read_cmd,
	input  vertex_job_pkg::read_data_t  read_data,
	input  logic                        job_pop,
	output vertex_job_pkg::vertex_job_t job,
	output logic                        job_valid,
	output vertex_job_pkg::vertex_id_t  pushed_count,
	output vertex_job_pkg::vertex_id_t  filtered_count
);
	import vertex_job_pkg::*;

	logic [NUM_FIELDS-1:0]          load;
	logic [NUM_FIELDS-1:0]          stream_busy;
	logic [NUM_FIELDS-1:0]          field_valid;
	vertex_value_t [NUM_FIELDS-1:0] field_value;
	vertex_line_t                   load_line;
	line_count_t                    load_count;
	logic                           reads_idle;
	logic                           drain;
	logic                           job_alfull;
	logic                           job_push;
	vertex_job_t                    job_in;

	////////////////////
	// request side
	////////////////////

	read_command_sequencer u_read_command_sequencer (
		.clock              (clock),
		.rstn               (rstn),
		.wed                (wed),
		.read_buffer_alfull (read_buffer_alfull),
		.reads_idle         (reads_idle),
		.job_alfull         (job_alfull),
		.stream_busy        (stream_busy),
		.read_cmd           (read_cmd)
	);

	read_data_router u_read_data_router (
		.clock          (clock),
		.rstn           (rstn),
		.read_cmd_valid (read_cmd.valid),
		.read_data      (read_data),
		.load           (load),
		.load_line      (load_line),
		.load_count     (load_count),
		.stream_busy    (stream_busy),
		.reads_idle     (reads_idle),
		.drain          (drain)
	);

	////////////////////
	// field streams
	////////////////////

	for (genvar f = 0; f < NUM_FIELDS; f++) begin : g_stream
		vertex_field_stream u_vertex_field_stream (
			.clock       (clock),
			.rstn        (rstn),
			.load        (load[f]),
			.drain       (drain),
			.load_line   (load_line),
			.load_count  (load_count),
			.field_value (field_value[f]),
			.field_valid (field_valid[f]),
			.busy        (stream_busy[f])
		);
	end

	vertex_assembler u_vertex_assembler (
		.clock          (clock),
		.rstn           (rstn),
		.field_value    (field_value),
		.field_valid    (field_valid),
		.job_in         (job_in),
		.job_push       (job_push),
		.pushed_count   (pushed_count),
		.filtered_count (filtered_count)
	);

	vertex_job_queue #(
		.JOB_DEPTH (JOB_DEPTH)
	) u_vertex_job_queue (
		.clock     (clock),
		.rstn      (rstn),
		.push      (job_push),
		.push_data (job_in),
		.pop       (job_pop),
		.head      (job),
		.valid     (job_valid),
		.alfull    (job_alfull)
	);

endmodule

// File: dv/vertex_job_control_assertions.sv
`timescale 1ns/1ps

module vertex_job_control_assertions (
	input logic       clock,
	input logic       rstn,
	input logic       cmd_valid,
	input logic [2:0] cmd_field,
	input logic       push,
	input logic       full,
	input logic       valid
);

	////////////////////
	// sequencer side
	////////////////////

	// back-to-back commands must walk to the next field
	assert property (@(posedge clock) disable iff (!rstn)
		(cmd_valid && $past(cmd_valid)) |-> (cmd_field != $past(cmd_field)))
		else $error("read command repeated on consecutive cycles");

	////////////////////
	// queue side
	////////////////////

	assert property (@(posedge clock) disable iff (!rstn) !(push && full))
		else $error("job queue pushed while full");

	assert property (@(posedge clock) !rstn |-> !valid)
		else $error("job valid high during reset");

	// first cycle out of reset
	assert property (@(posedge clock) $rose(rstn) |-> !valid)
		else $error("job valid high right after reset");

endmodule

// File: dv/vertex_job_control_tb.sv
`timescale 1ns/1ps

module vertex_job_control_tb;
	import vertex_job_pkg::*;

	localparam int MAX_VERTICES = 64;
	localparam int GOLDEN_WORDS = 1 + NUM_FIELDS + MAX_VERTICES * NUM_FIELDS + 2;

	logic          clock;
	logic          rstn;
	wed_t          wed;
	logic          read_buffer_alfull = 1'b0;
	read_cmd_t     read_cmd;
	read_data_t    read_data = '0;
	logic          job_pop = 1'b0;
	vertex_job_t   job;
	logic          job_valid;
	vertex_id_t    pushed_count, filtered_count;

	logic [63:0]   golden [GOLDEN_WORDS];
	bit            loaded;
	int            num_vertices, exp_pushed, exp_filtered;
	int            mismatches, other_errors;
	int            cmd_total, popped, next_vertex, cycle;
	logic [31:0]   mem_rng, pop_rng;
	byte_addr_t    pend_addr [$]; // reads the memory model still owes
	int            pend_field [$];
	int            pend_count [$];
	int            pend_due [$];

	vertex_job_control #(
		.JOB_DEPTH (16)
	) u_vertex_job_control (
		.clock              (clock),
		.rstn               (rstn),
		.wed                (wed),
		.read_buffer_alfull (read_buffer_alfull),
		.read_cmd           (read_cmd),
		.read_data          (read_data),
		.job_pop            (job_pop),
		.job                (job),
		.job_valid          (job_valid),
		.pushed_count       (pushed_count),
		.filtered_count     (filtered_count)
	);

	bind read_command_sequencer vertex_job_control_assertions u_seq_assertions (
		.clock (clock), .rstn (rstn), .cmd_valid (read_cmd.valid),
		.cmd_field (read_cmd.field), .push (1'b0), .full (1'b0), .valid (1'b0)
	);
	bind vertex_job_queue vertex_job_control_assertions u_queue_assertions (
		.clock (clock), .rstn (rstn), .cmd_valid (1'b0), .cmd_field (3'd0),
		.push (push), .full (full), .valid (valid)
	);

	always #50 clock = ~clock;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic vertex_value_t golden_value(input int v, input int f);
		return golden[1 + NUM_FIELDS + v * NUM_FIELDS + f][31:0];
	endfunction

	function automatic int pow2_bytes(input int bytes);
		int size;
		size = 1;
		while (size < bytes)
			size = size * 2;
		return size;
	endfunction

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual) begin
			$display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
			mismatches++;
		end
	endtask

	// next surviving vertex in id order
	task automatic check_popped_job();
		while (next_vertex < num_vertices && golden_value(next_vertex, int'(INV_OUT_DEGREE)) == 0)
			next_vertex++;
		if (next_vertex >= num_vertices) begin
			$display("ERROR: job popped after the last expected vertex, id %0d", job.id);
			other_errors++;
		end else begin
			check_value("job valid bit", 64'(1), 64'(job.valid));
			check_value("job id", 64'(next_vertex), 64'(job.id));
			check_value("job in_degree", golden_value(next_vertex, 0), job.in_degree);
			check_value("job out_degree", golden_value(next_vertex, 1), job.out_degree);
			check_value("job edges_idx", golden_value(next_vertex, 2), job.edges_idx);
			check_value("job inv_in_degree", golden_value(next_vertex, 3), job.inv_in_degree);
			check_value("job inv_out_degree", golden_value(next_vertex, 4), job.inv_out_degree);
			check_value("job inv_edges_idx", golden_value(next_vertex, 5), job.inv_edges_idx);
			next_vertex++;
		end
		popped++;
	endtask

	////////////////////
	// memory model
	////////////////////

	always @(posedge clock) begin : memory_model
		read_data_t beat;
		int pick, batch, fld, exp_count, start;
		if (rstn) begin
			cycle = cycle + 1;
			mem_rng = xorshift(mem_rng);
			read_buffer_alfull <= (mem_rng[1:0] == 2'b00); // stall about one cycle in four
			if (read_cmd.valid) begin
				batch = cmd_total / NUM_FIELDS;
				fld = cmd_total % NUM_FIELDS;
				exp_count = num_vertices - batch * LINE_VERTICES;
				if (exp_count > LINE_VERTICES)
					exp_count = LINE_VERTICES;
				if (exp_count <= 0) begin
					$display("ERROR: read command issued after the last line");
					other_errors++;
				end
				check_value("command field", 64'(fld), 64'(read_cmd.field));
				check_value("command address", golden[1 + fld] + 64'(batch * LINE_BYTES),
					read_cmd.address);
				check_value("command count", 64'(exp_count), 64'(read_cmd.count));
				check_value("command size", 64'(pow2_bytes(exp_count * VERTEX_BYTES)),
					64'(read_cmd.size));
				mem_rng = xorshift(mem_rng);
				pend_addr.push_back(read_cmd.address);
				pend_field.push_back(int'(read_cmd.field));
				pend_count.push_back(int'(read_cmd.count));
				pend_due.push_back(cycle + 2 + int'(mem_rng[2:0])); // 2 to 9 cycles
				cmd_total++;
				if (pend_due.size() > NUM_FIELDS) begin
					$display("ERROR: more than six reads outstanding");
					other_errors++;
				end
			end
			beat = '0;
			pick = -1;
			for (int i = 0; i < pend_due.size(); i++)
				if (pick < 0 && pend_due[i] <= cycle)
					pick = i;
			if (pick >= 0) begin
				fld = pend_field[pick];
				start = int'((pend_addr[pick] - golden[1 + fld]) / VERTEX_BYTES);
				beat.valid = 1'b1;
				beat.field = vertex_field_e'(fld);
				beat.count = line_count_t'(pend_count[pick]);
				for (int e = 0; e < LINE_VERTICES; e++)
					if (e < pend_count[pick])
						beat.line[e] = golden_value(start + e, fld);
				pend_addr.delete(pick);
				pend_field.delete(pick);
				pend_count.delete(pick);
				pend_due.delete(pick);
			end
			read_data <= beat;
		end
	end

	// slow reader that never pops two cycles in a row
	always @(posedge clock) begin : job_reader
		if (rstn) begin
			pop_rng = xorshift(pop_rng);
			if (job_pop) begin
				job_pop <= 1'b0;
			end else if (job_valid && pop_rng[1:0] == 2'b01) begin
				check_popped_job();
				job_pop <= 1'b1;
			end
		end
	end

	initial begin : watchdog
		wait (loaded);
		repeat (16 + 200 * num_vertices) @(posedge clock);
		$display("ERROR: timeout, %0d of %0d jobs popped", popped, exp_pushed);
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		wed_t desc;
		clock = 1'b0;
		rstn = 1'b0;
		wed = '0;
		mem_rng = 32'd96269;
		pop_rng = xorshift(xorshift(mem_rng));
		$readmemh("dv/vertex_golden.txt", golden);
		num_vertices = int'(golden[0]);
		exp_pushed = int'(golden[1 + NUM_FIELDS + num_vertices * NUM_FIELDS]);
		exp_filtered = int'(golden[2 + NUM_FIELDS + num_vertices * NUM_FIELDS]);
		loaded = 1'b1;
		repeat (16) @(posedge clock);
		check_value("reset command valid", 64'(0), 64'(read_cmd.valid));
		check_value("reset job valid", 64'(0), 64'(job_valid));
		check_value("reset pushed count", 64'(0), 64'(pushed_count));
		check_value("reset filtered count", 64'(0), 64'(filtered_count));
		rstn <= 1'b1;
		@(posedge clock);
		desc = '0;
		desc.valid = 1'b1;
		desc.num_vertices = vertex_id_t'(num_vertices);
		for (int f = 0; f < NUM_FIELDS; f++)
			desc.base[f] = golden[1 + f];
		wed <= desc; // held for the whole run
		while (popped < exp_pushed)
			@(posedge clock);
		repeat (20) @(posedge clock); // catch late or duplicate jobs
		check_value("pushed count", 64'(exp_pushed), 64'(pushed_count));
		check_value("filtered count", 64'(exp_filtered), 64'(filtered_count));
		check_value("counts sum", 64'(num_vertices), 64'(pushed_count + filtered_count));
		check_value("command total", 64'(NUM_FIELDS * ((num_vertices + 7) / 8)), 64'(cmd_total));
		check_value("queue empty at end", 64'(0), 64'(job_valid));
		$display("errors: %0d value mismatches, %0d other failures", mismatches, other_errors);
		if (mismatches + other_errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: dv/vertex_golden.txt
// word 0 vertex count, words 1-6 array bases in tag order
// one row per vertex: in_deg out_deg edges_idx inv_in inv_out inv_edges, last row pushed filtered
0000000000000014
0000000000010000
0000000000020000
0000000000030000
0000000000040000
0000000000050000
0000000000060000
00000002 00000003 00000000 00000001 00000003 00000000
00000001 00000002 00000003 00000002 00000001 00000002
00000004 00000001 00000005 00000003 00000002 00000006
00000003 00000000 00000006 00000007 00000000 00000009
00000000 00000005 00000006 00000009 00000004 0000000a
00000002 00000002 0000000b 00000009 00000002 0000000f
00000005 00000001 0000000d 0000000b 00000006 00000011
00000001 00000000 0000000e 00000010 00000000 00000014
00000003 00000004 0000000e 00000011 00000005 00000016
00000002 00000001 00000012 00000014 00000008 00000019
00000006 00000003 00000013 00000016 00000009 0000001d
00000001 00000002 00000016 0000001c 0000000c 0000001e
00000000 00000000 00000018 0000001d 00000000 00000020
00000004 00000002 00000018 0000001d 0000000e 00000024
00000002 00000005 0000001a 00000021 0000000f 00000026
00000003 00000001 0000001f 00000023 00000011 00000029
00000001 00000002 00000020 00000026 00000012 0000002a
00000005 00000003 00000022 00000027 00000013 0000002f
00000002 00000000 00000025 0000002c 00000000 00000031
00000001 00000001 00000025 0000002d 00000015 00000033
00000010 00000004

// File: flist.f
source/vertex_job_pkg.sv
source/read_command_sequencer.sv
source/read_data_router.sv
source/vertex_field_stream.sv
source/vertex_assembler.sv
source/vertex_job_queue.sv
source/vertex_job_control.sv
dv/vertex_job_control_assertions.sv
dv/vertex_job_control_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module vertex_job_control_tb \
	-f flist.f -o vertex_job_control_sim > build.log 2>&1 &&
	./obj_dir/vertex_job_control_sim > sim.log 2>&1 ||
	{ cat build.log sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "^RESULT: PASS$" sim.log && exit 0 || exit 1
